/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= plane_deriver_tb
FILELIST ?= compile.f

.PHONY: run lint clean

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

/* compile.f */
+incdir+include
verilog/fixed_point_pkg.sv
verilog/plane_schedule_pkg.sv
verilog/fma_pipe.sv
verilog/operand_scoreboard.sv
verilog/plane_normalizer.sv
verilog/plane_deriver.sv
verification/plane_deriver_chk.sv
verification/plane_deriver_tb.sv

/* verification/plane_deriver_chk.sv */
`timescale 1ns/1ps

module plane_deriver_chk (
    input logic                     clock,
    input logic                     rst_n,
    input logic                     ivalid,
    input logic                     iready,
    input logic                     ovalid,
    input logic                     oacknowledge,
    input fixed_point_pkg::narrow_t n_x, n_y, n_z,
    input fixed_point_pkg::narrow_t d,
    input logic                     result_valid,
    input logic [4:0]               result_tag,
    input logic [1:0]               tag_state
);

    localparam logic [4:0] first_op_tag = 5'(plane_schedule_pkg::num_points);
    localparam logic [4:0] last_op_tag =
        5'(plane_schedule_pkg::num_points + plane_schedule_pkg::num_ops - 1);
    // encoding of the running state in the scoreboard
    localparam logic [1:0] running = 2'd1;

    held_until_ack: assert property (@(posedge clock) disable iff (!rst_n)
        ovalid && !oacknowledge |=> ovalid && $stable({n_x, n_y, n_z, d}))
        else $error("ovalid or the results changed before the acknowledge");

    never_both_high: assert property (@(posedge clock) disable iff (!rst_n)
        !(ovalid && iready))
        else $error("ovalid and iready are high together");

    iready_falls: assert property (@(posedge clock) disable iff (!rst_n)
        ivalid && iready |=> !iready)
        else $error("iready stayed high after a point set was accepted");

    // a returning result must belong to an operation that is in flight
    tag_running: assert property (@(posedge clock) disable iff (!rst_n)
        result_valid |-> result_tag >= first_op_tag && result_tag <= last_op_tag
                         && tag_state == running)
        else $error("result tag %0d does not name a running variable", result_tag);

endmodule

/* include/plane_model.svh */
`ifndef PLANE_MODEL_SVH
`define PLANE_MODEL_SVH

function automatic fixed_point_pkg::narrow_t narrow_value(input fixed_point_pkg::wide_t v);
    return v[fixed_point_pkg::fraction_shift +: fixed_point_pkg::narrow_bits];
endfunction

function automatic fixed_point_pkg::wide_t widen_value(input fixed_point_pkg::narrow_t v);
    return fixed_point_pkg::wide_t'(v) <<< fixed_point_pkg::fraction_shift;
endfunction

// both multiplier operands pass through the narrowing rule first
function automatic fixed_point_pkg::wide_t narrowed_product(input fixed_point_pkg::wide_t x,
                                                            input fixed_point_pkg::wide_t y);
    return fixed_point_pkg::wide_t'(narrow_value(x)) * fixed_point_pkg::wide_t'(narrow_value(y));
endfunction

function automatic void expected_plane(input fixed_point_pkg::narrow_t a [3],
                                       input fixed_point_pkg::narrow_t b [3],
                                       input fixed_point_pkg::narrow_t c [3],
                                       output fixed_point_pkg::narrow_t n [3],
                                       output fixed_point_pkg::narrow_t d);
    fixed_point_pkg::wide_t v1 [3];
    fixed_point_pkg::wide_t v2 [3];
    fixed_point_pkg::wide_t nw [3];
    fixed_point_pkg::wide_t dw;
    fixed_point_pkg::wide_t dabs;
    for (int i = 0; i < 3; i++) begin
        v1[i] = widen_value(a[i]) - widen_value(b[i]);
        v2[i] = widen_value(a[i]) - widen_value(c[i]);
    end
    nw[0] = narrowed_product(v1[1], v2[2]) - narrowed_product(v1[2], v2[1]);
    nw[1] = narrowed_product(v1[2], v2[0]) - narrowed_product(v1[0], v2[2]);
    nw[2] = narrowed_product(v1[0], v2[1]) - narrowed_product(v1[1], v2[0]);
    dw = 0;
    for (int i = 0; i < 3; i++) begin
        dw = dw + narrowed_product(nw[i], widen_value(a[i]));
    end
    dabs = (dw < 0) ? -dw : dw;
    while (dabs[fixed_point_pkg::wide_bits-1 -: fixed_point_pkg::wide_ibits]
           > fixed_point_pkg::wide_ibits'(fixed_point_pkg::scale_limit)) begin
        for (int i = 0; i < 3; i++) begin
            nw[i] = nw[i] >>> 1;
        end
        dw = dw >>> 1;
        dabs = (dw < 0) ? -dw : dw;
    end
    for (int i = 0; i < 3; i++) begin
        n[i] = narrow_value(nw[i]);
    end
    d = narrow_value(dw);
endfunction

`endif

/* verification/plane_deriver_tb.sv */
`timescale 1ns/1ps

module plane_deriver_tb;

    `include "plane_model.svh"

    localparam int fma_latency = 3;
    localparam int num_random = 100;
    localparam int num_delayed = 50;
    localparam int num_large = 30;
    localparam int num_degenerate = 20;
    // generous bound for one plane including the longest acknowledge delay
    localparam int cycles_per_plane = 200;
    localparam int timeout_cycles =
        (num_random + num_delayed + num_large + num_degenerate) * cycles_per_plane;

    logic                     clock;
    logic                     rst_n;
    logic                     ivalid;
    logic                     iready;
    fixed_point_pkg::narrow_t a_x, a_y, a_z;
    fixed_point_pkg::narrow_t b_x, b_y, b_z;
    fixed_point_pkg::narrow_t c_x, c_y, c_z;
    logic                     ovalid;
    logic                     oacknowledge;
    fixed_point_pkg::narrow_t n_x, n_y, n_z;
    fixed_point_pkg::narrow_t d;

    int checks;
    int errors;
    int tests_run;
    int tests_failed;
    int cycle_count;
    fixed_point_pkg::narrow_t last_n [3];
    fixed_point_pkg::narrow_t last_d;

    plane_deriver #(
        .fma_latency(fma_latency)
    ) dut (
        .clock(clock), .rst_n(rst_n), .ivalid(ivalid), .iready(iready),
        .a_x(a_x), .a_y(a_y), .a_z(a_z),
        .b_x(b_x), .b_y(b_y), .b_z(b_z),
        .c_x(c_x), .c_y(c_y), .c_z(c_z),
        .ovalid(ovalid), .oacknowledge(oacknowledge),
        .n_x(n_x), .n_y(n_y), .n_z(n_z), .d(d)
    );

    bind plane_deriver plane_deriver_chk chk (
        .clock(clock), .rst_n(rst_n), .ivalid(ivalid), .iready(iready),
        .ovalid(ovalid), .oacknowledge(oacknowledge),
        .n_x(n_x), .n_y(n_y), .n_z(n_z), .d(d),
        .result_valid(result_valid), .result_tag(result_tag),
        .tag_state(scoreboard.state[scoreboard.result_op])
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: the DUT did not finish within %0d cycles", timeout_cycles);
        $display("Testbench failed");
        $finish;
    end

    // integer part below int_limit, random 20-bit fraction, random sign
    function automatic fixed_point_pkg::narrow_t random_coord(input int int_limit);
        fixed_point_pkg::narrow_t mag;
        mag = fixed_point_pkg::narrow_t'(($urandom_range(32'(int_limit - 1)) << 20)
                                         | ($urandom & 32'h000f_ffff));
        if ($urandom_range(1) == 1) begin
            return -mag;
        end
        return mag;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic drive_points(input fixed_point_pkg::narrow_t pa [3],
                                input fixed_point_pkg::narrow_t pb [3],
                                input fixed_point_pkg::narrow_t pc [3]);
        a_x = pa[0];
        a_y = pa[1];
        a_z = pa[2];
        b_x = pb[0];
        b_y = pb[1];
        b_z = pb[2];
        c_x = pc[0];
        c_y = pc[1];
        c_z = pc[2];
    endtask

    // new points on every busy cycle that the DUT must ignore
    task automatic drive_junk();
        fixed_point_pkg::narrow_t ja [3];
        fixed_point_pkg::narrow_t jb [3];
        fixed_point_pkg::narrow_t jc [3];
        for (int k = 0; k < 3; k++) begin
            ja[k] = random_coord(8);
            jb[k] = random_coord(8);
            jc[k] = random_coord(8);
        end
        ivalid = 1'b1;
        drive_points(ja, jb, jc);
    endtask

    task automatic run_plane(input fixed_point_pkg::narrow_t pa [3],
                             input fixed_point_pkg::narrow_t pb [3],
                             input fixed_point_pkg::narrow_t pc [3],
                             input int ack_delay, input bit hold_busy);
        fixed_point_pkg::narrow_t exp_n [3];
        fixed_point_pkg::narrow_t exp_d;
        longint d_mag;
        expected_plane(pa, pb, pc, exp_n, exp_d);
        while (!iready) begin
            @(negedge clock);
        end
        ivalid = 1'b1;
        drive_points(pa, pb, pc);
        @(negedge clock);
        check_value("iready", 32'(iready), 32'd0);
        while (!ovalid) begin
            if (hold_busy) begin
                drive_junk();
            end else begin
                ivalid = 1'b0;
            end
            @(negedge clock);
        end
        for (int i = 0; i < ack_delay; i++) begin
            if (hold_busy) begin
                drive_junk();
            end
            @(negedge clock);
            check_value("ovalid", 32'(ovalid), 32'd1);
        end
        oacknowledge = 1'b1;
        check_value("n_x", n_x, exp_n[0]);
        check_value("n_y", n_y, exp_n[1]);
        check_value("n_z", n_z, exp_n[2]);
        check_value("d", d, exp_d);
        d_mag = longint'(d);
        if (d_mag < 0) begin
            d_mag = -d_mag;
        end
        checks++;
        if ((d_mag >> fixed_point_pkg::narrow_fbits) > fixed_point_pkg::scale_limit) begin
            errors++;
            $display("[FAIL] %0t integer magnitude of d is above the scale limit", $time);
        end
        last_n = '{n_x, n_y, n_z};
        last_d = d;
        @(negedge clock);
        oacknowledge = 1'b0;
        ivalid = 1'b0;
    endtask

    task automatic report_test(input string name, input int first_error);
        tests_run++;
        if (errors != first_error) begin
            tests_failed++;
        end
        $display("test %0d, %s: %0d errors", tests_run, name, errors - first_error);
    endtask

    initial begin
        fixed_point_pkg::narrow_t pa [3];
        fixed_point_pkg::narrow_t pb [3];
        fixed_point_pkg::narrow_t pc [3];
        fixed_point_pkg::narrow_t p;
        fixed_point_pkg::narrow_t step;
        logic [2:0] flip;
        int first_error;

        void'($urandom(32'hed4cb7c2));
        checks = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        rst_n = 1'b0;
        ivalid = 1'b0;
        oacknowledge = 1'b0;
        pa = '{0, 0, 0};
        drive_points(pa, pa, pa);
        repeat (16) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);

        first_error = errors;
        check_value("iready", 32'(iready), 32'd1);
        check_value("ovalid", 32'(ovalid), 32'd0);
        report_test("reset values", first_error);

        first_error = errors;
        for (int t = 0; t < num_random; t++) begin
            for (int k = 0; k < 3; k++) begin
                pa[k] = random_coord(8);
                pb[k] = random_coord(8);
                pc[k] = random_coord(8);
            end
            run_plane(pa, pb, pc, 0, 1'b0);
        end
        report_test("random planes, immediate acknowledge", first_error);

        first_error = errors;
        for (int t = 0; t < num_delayed; t++) begin
            for (int k = 0; k < 3; k++) begin
                pa[k] = random_coord(8);
                pb[k] = random_coord(8);
                pc[k] = random_coord(8);
            end
            run_plane(pa, pb, pc, int'($urandom_range(10)), 1'b1);
        end
        report_test("delayed acknowledge, ivalid held while busy", first_error);

        // |d| = 4 p^3 with p in [7, 8) always forces a scale-down
        first_error = errors;
        for (int t = 0; t < num_large; t++) begin
            p = fixed_point_pkg::narrow_t'((7 << 20) | ($urandom & 32'h000f_ffff));
            flip = 3'($urandom);
            pa = '{p, p, p};
            pb = '{-p, p, -p};
            pc = '{p, -p, -p};
            for (int k = 0; k < 3; k++) begin
                if (flip[k]) begin
                    pa[k] = -pa[k];
                    pb[k] = -pb[k];
                    pc[k] = -pc[k];
                end
            end
            run_plane(pa, pb, pc, int'($urandom_range(3)), 1'b0);
        end
        report_test("large points, scaled plane", first_error);

        first_error = errors;
        for (int t = 0; t < num_degenerate; t++) begin
            for (int k = 0; k < 3; k++) begin
                pa[k] = random_coord(2);
                step = random_coord(2);
                if (t % 2 == 0) begin
                    pb[k] = pa[k];
                    pc[k] = random_coord(8);
                end else begin
                    pb[k] = pa[k] + step;
                    pc[k] = pa[k] + step + step;
                end
            end
            run_plane(pa, pb, pc, 0, 1'b0);
            check_value("n_x", last_n[0], 32'd0);
            check_value("n_y", last_n[1], 32'd0);
            check_value("n_z", last_n[2], 32'd0);
            check_value("d", last_d, 32'd0);
        end
        report_test("duplicate and collinear points", first_error);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* verilog/fixed_point_pkg.sv */
package fixed_point_pkg;

    // narrow format 12.20, used for multiplier operands and results
    localparam int narrow_ibits = 12;
    localparam int narrow_fbits = 20;
    localparam int narrow_bits = narrow_ibits + narrow_fbits;

    // wide format 24.40, holds any exact product of two narrow values
    localparam int wide_ibits = 24;
    localparam int wide_fbits = 40;
    localparam int wide_bits = wide_ibits + wide_fbits;

    // shift that moves a narrow value into the wide format
    localparam int fraction_shift = wide_fbits - narrow_fbits;

    // largest allowed integer magnitude of d after scaling
    localparam int scale_limit = 1 << (narrow_ibits - 2);

    typedef logic signed [narrow_bits-1:0] narrow_t;
    typedef logic signed [wide_bits-1:0] wide_t;

    // narrowing keeps wide bits [fraction_shift +: narrow_bits]
    // this floors the fraction and drops the upper integer bits

endpackage

/* verilog/fma_pipe.sv */
`timescale 1ns/1ps

module fma_pipe #(
    parameter int fma_latency = 3
) (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        issue_valid,
    input  plane_schedule_pkg::var_id_t issue_tag,
    input  fixed_point_pkg::narrow_t    a,
    input  fixed_point_pkg::narrow_t    b,
    input  fixed_point_pkg::wide_t      c,
    output logic                        result_valid,
    output plane_schedule_pkg::var_id_t result_tag,
    output fixed_point_pkg::wide_t      r
);

    fixed_point_pkg::wide_t sum;

    logic                        valid_q [fma_latency];
    plane_schedule_pkg::var_id_t tag_q [fma_latency];
    fixed_point_pkg::wide_t      sum_q [fma_latency];

    // the product of two 12.20 values is exact in 24.40
    assign sum = fixed_point_pkg::wide_t'(a) * fixed_point_pkg::wide_t'(b) + c;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < fma_latency; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            valid_q[0] <= issue_valid;
            for (int i = 1; i < fma_latency; i++) begin
                valid_q[i] <= valid_q[i - 1];
            end
        end
    end

    // tag and sum ride alongside the valid bit
    always_ff @(posedge clock) begin
        tag_q[0] <= issue_tag;
        sum_q[0] <= sum;
        for (int i = 1; i < fma_latency; i++) begin
            tag_q[i] <= tag_q[i - 1];
            sum_q[i] <= sum_q[i - 1];
        end
    end

    assign result_valid = valid_q[fma_latency - 1];
    assign result_tag = tag_q[fma_latency - 1];
    assign r = sum_q[fma_latency - 1];

endmodule

/* verilog/operand_scoreboard.sv */
`timescale 1ns/1ps

module operand_scoreboard (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        start,
    input  fixed_point_pkg::narrow_t    a_x, a_y, a_z,
    input  fixed_point_pkg::narrow_t    b_x, b_y, b_z,
    input  fixed_point_pkg::narrow_t    c_x, c_y, c_z,
    output logic                        issue_valid,
    output plane_schedule_pkg::var_id_t issue_tag,
    output fixed_point_pkg::narrow_t    fma_a,
    output fixed_point_pkg::narrow_t    fma_b,
    output fixed_point_pkg::wide_t      fma_c,
    input  logic                        result_valid,
    input  plane_schedule_pkg::var_id_t result_tag,
    input  fixed_point_pkg::wide_t      result,
    output logic                        done,
    output fixed_point_pkg::wide_t      n_x_wide, n_y_wide, n_z_wide,
    output fixed_point_pkg::wide_t      d_wide
);

    localparam int num_points = plane_schedule_pkg::num_points;
    localparam int num_ops = plane_schedule_pkg::num_ops;

    typedef enum logic [1:0] {st_pending, st_running, st_finished} var_state_t;

    fixed_point_pkg::narrow_t point_in [num_points];
    fixed_point_pkg::wide_t   point_val [num_points];
    fixed_point_pkg::wide_t   value [num_ops];
    var_state_t               state [num_ops];

    // every source code maps to a value and a ready flag, results bypassed in
    fixed_point_pkg::wide_t src_val [32];
    logic                   src_ready [32];

    logic       busy;
    logic       all_finished;
    logic       pick_valid;
    logic [3:0] pick;
    logic [3:0] result_op;

    assign point_in = '{a_x, a_y, a_z, b_x, b_y, b_z, c_x, c_y, c_z};
    assign result_op = 4'(result_tag - 5'(num_points));

    always_comb begin
        for (int i = 0; i < 32; i++) begin
            src_val[i] = '0;
            src_ready[i] = 1'b0;
        end
        for (int i = 0; i < num_points; i++) begin
            src_val[i] = point_val[i];
            src_ready[i] = 1'b1;
        end
        for (int i = 0; i < num_ops; i++) begin
            if (result_valid && result_tag == plane_schedule_pkg::var_id_t'(num_points + i)) begin
                src_val[num_points + i] = result;
                src_ready[num_points + i] = 1'b1;
            end else begin
                src_val[num_points + i] = value[i];
                src_ready[num_points + i] = (state[i] == st_finished);
            end
        end
        src_ready[plane_schedule_pkg::src_zero] = 1'b1;
        src_val[plane_schedule_pkg::src_minus_one] = -(64'sd1 <<< fixed_point_pkg::wide_fbits);
        src_ready[plane_schedule_pkg::src_minus_one] = 1'b1;
    end

    // fixed priority, the lowest ready entry wins
    always_comb begin
        pick_valid = 1'b0;
        pick = '0;
        all_finished = 1'b1;
        for (int i = num_ops - 1; i >= 0; i--) begin
            if (state[i] == st_pending && src_ready[plane_schedule_pkg::op_table[i].a]
                    && src_ready[plane_schedule_pkg::op_table[i].b]
                    && src_ready[plane_schedule_pkg::op_table[i].c]) begin
                pick_valid = 1'b1;
                pick = 4'(i);
            end
            if (!src_ready[num_points + i]) begin
                all_finished = 1'b0;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            issue_valid <= 1'b0;
            for (int i = 0; i < num_ops; i++) begin
                state[i] <= st_pending;
            end
        end else begin
            done <= busy && all_finished;
            issue_valid <= busy && pick_valid;
            if (start) begin
                busy <= 1'b1;
                for (int i = 0; i < num_ops; i++) begin
                    state[i] <= st_pending;
                end
            end else if (busy) begin
                if (all_finished) begin
                    busy <= 1'b0;
                end
                if (result_valid) begin
                    state[result_op] <= st_finished;
                end
                if (pick_valid) begin
                    state[pick] <= st_running;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            for (int i = 0; i < num_points; i++) begin
                point_val[i] <= fixed_point_pkg::wide_t'(point_in[i]) <<< fixed_point_pkg::fraction_shift;
            end
        end
        if (result_valid) begin
            value[result_op] <= result;
        end
        // multiplier operands narrowed on the way out
        issue_tag <= plane_schedule_pkg::var_id_t'(5'(pick) + 5'(num_points));
        fma_a <= src_val[plane_schedule_pkg::op_table[pick].a][fixed_point_pkg::fraction_shift +:
                 fixed_point_pkg::narrow_bits];
        fma_b <= src_val[plane_schedule_pkg::op_table[pick].b][fixed_point_pkg::fraction_shift +:
                 fixed_point_pkg::narrow_bits];
        fma_c <= plane_schedule_pkg::op_table[pick].negate_c
                 ? -src_val[plane_schedule_pkg::op_table[pick].c]
                 : src_val[plane_schedule_pkg::op_table[pick].c];
    end

    assign n_x_wide = value[plane_schedule_pkg::id_nx2 - num_points];
    assign n_y_wide = value[plane_schedule_pkg::id_ny2 - num_points];
    assign n_z_wide = value[plane_schedule_pkg::id_nz2 - num_points];
    assign d_wide = value[plane_schedule_pkg::id_dz - num_points];

endmodule

/* verilog/plane_deriver.sv */
`timescale 1ns/1ps

module plane_deriver #(
    parameter int fma_latency = 3
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     ivalid,
    output logic                     iready,
    input  fixed_point_pkg::narrow_t a_x, a_y, a_z,
    input  fixed_point_pkg::narrow_t b_x, b_y, b_z,
    input  fixed_point_pkg::narrow_t c_x, c_y, c_z,
    output logic                     ovalid,
    input  logic                     oacknowledge,
    output fixed_point_pkg::narrow_t n_x, n_y, n_z,
    output fixed_point_pkg::narrow_t d
);

    logic                        start;
    logic                        issue_valid;
    plane_schedule_pkg::var_id_t issue_tag;
    fixed_point_pkg::narrow_t    fma_a, fma_b;
    fixed_point_pkg::wide_t      fma_c, fma_r;
    logic                        result_valid;
    plane_schedule_pkg::var_id_t result_tag;
    logic                        sb_done;
    fixed_point_pkg::wide_t      n_x_wide, n_y_wide, n_z_wide, d_wide;
    logic                        norm_finish;
    fixed_point_pkg::narrow_t    norm_n_x, norm_n_y, norm_n_z, norm_d;

    assign start = ivalid && iready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            iready <= 1'b1;
            ovalid <= 1'b0;
        end else begin
            if (start) begin
                iready <= 1'b0;
            end
            if (norm_finish) begin
                ovalid <= 1'b1;
            end else if (ovalid && oacknowledge) begin
                // ready for the next point set once the result is taken
                ovalid <= 1'b0;
                iready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (norm_finish) begin
            n_x <= norm_n_x;
            n_y <= norm_n_y;
            n_z <= norm_n_z;
            d <= norm_d;
        end
    end

    fma_pipe #(
        .fma_latency(fma_latency)
    ) fma_unit (
        .clock(clock), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_tag(issue_tag),
        .a(fma_a), .b(fma_b), .c(fma_c),
        .result_valid(result_valid), .result_tag(result_tag), .r(fma_r)
    );

    operand_scoreboard scoreboard (
        .clock(clock), .rst_n(rst_n), .start(start),
        .a_x(a_x), .a_y(a_y), .a_z(a_z),
        .b_x(b_x), .b_y(b_y), .b_z(b_z),
        .c_x(c_x), .c_y(c_y), .c_z(c_z),
        .issue_valid(issue_valid), .issue_tag(issue_tag),
        .fma_a(fma_a), .fma_b(fma_b), .fma_c(fma_c),
        .result_valid(result_valid), .result_tag(result_tag), .result(fma_r),
        .done(sb_done),
        .n_x_wide(n_x_wide), .n_y_wide(n_y_wide), .n_z_wide(n_z_wide), .d_wide(d_wide)
    );

    plane_normalizer normalizer (
        .clock(clock), .rst_n(rst_n), .start(sb_done),
        .n_x_wide(n_x_wide), .n_y_wide(n_y_wide), .n_z_wide(n_z_wide), .d_wide(d_wide),
        .finish(norm_finish),
        .n_x(norm_n_x), .n_y(norm_n_y), .n_z(norm_n_z), .d(norm_d)
    );

endmodule

/* verilog/plane_normalizer.sv */
`timescale 1ns/1ps

module plane_normalizer (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     start,
    input  fixed_point_pkg::wide_t   n_x_wide, n_y_wide, n_z_wide,
    input  fixed_point_pkg::wide_t   d_wide,
    output logic                     finish,
    output fixed_point_pkg::narrow_t n_x, n_y, n_z,
    output fixed_point_pkg::narrow_t d
);

    logic                   busy;
    logic                   over_limit;
    fixed_point_pkg::wide_t nx_q, ny_q, nz_q, d_q;
    fixed_point_pkg::wide_t d_abs;

    assign d_abs = d_q[fixed_point_pkg::wide_bits-1] ? -d_q : d_q;
    // only the integer part of |d| is compared
    assign over_limit = d_abs[fixed_point_pkg::wide_bits-1 -: fixed_point_pkg::wide_ibits]
                        > fixed_point_pkg::wide_ibits'(fixed_point_pkg::scale_limit);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            finish <= 1'b0;
        end else begin
            finish <= busy && !over_limit;
            if (start) begin
                busy <= 1'b1;
            end else if (busy && !over_limit) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            nx_q <= n_x_wide;
            ny_q <= n_y_wide;
            nz_q <= n_z_wide;
            d_q <= d_wide;
        end else if (busy && over_limit) begin
            // halve the whole plane, which leaves it unchanged
            nx_q <= nx_q >>> 1;
            ny_q <= ny_q >>> 1;
            nz_q <= nz_q >>> 1;
            d_q <= d_q >>> 1;
        end
        if (busy && !over_limit) begin
            n_x <= nx_q[fixed_point_pkg::fraction_shift +: fixed_point_pkg::narrow_bits];
            n_y <= ny_q[fixed_point_pkg::fraction_shift +: fixed_point_pkg::narrow_bits];
            n_z <= nz_q[fixed_point_pkg::fraction_shift +: fixed_point_pkg::narrow_bits];
            d <= d_q[fixed_point_pkg::fraction_shift +: fixed_point_pkg::narrow_bits];
        end
    end

endmodule

/* verilog/plane_schedule_pkg.sv */
package plane_schedule_pkg;

    // point coordinates first, then the computed variables in issue priority
    typedef enum logic [4:0] {
        id_ax, id_ay, id_az, id_bx, id_by, id_bz, id_cx, id_cy, id_cz,
        id_v1x, id_v1y, id_v1z, id_v2x, id_v2y, id_v2z,
        id_nx1, id_ny1, id_nz1, id_nx2, id_ny2, id_nz2,
        id_dx, id_dy, id_dz
    } var_id_t;

    localparam int num_points = 9;
    localparam int num_ops = 15;

    // operand source, a variable id or one of two fixed constants
    typedef logic [4:0] src_t;
    localparam src_t src_zero = 5'd24;
    localparam src_t src_minus_one = 5'd25;

    typedef struct packed {
        src_t a;
        src_t b;
        src_t c;
        logic negate_c;
    } op_entry_t;

    // r = a * b + (negate_c ? -c : c), one entry per computed variable
    localparam op_entry_t op_table [num_ops] = '{
        '{id_bx, src_minus_one, id_ax, 1'b0},
        '{id_by, src_minus_one, id_ay, 1'b0},
        '{id_bz, src_minus_one, id_az, 1'b0},
        '{id_cx, src_minus_one, id_ax, 1'b0},
        '{id_cy, src_minus_one, id_ay, 1'b0},
        '{id_cz, src_minus_one, id_az, 1'b0},
        '{id_v1z, id_v2y, src_zero, 1'b0},
        '{id_v1x, id_v2z, src_zero, 1'b0},
        '{id_v1y, id_v2x, src_zero, 1'b0},
        '{id_v1y, id_v2z, id_nx1, 1'b1},
        '{id_v1z, id_v2x, id_ny1, 1'b1},
        '{id_v1x, id_v2y, id_nz1, 1'b1},
        '{id_nx2, id_ax, src_zero, 1'b0},
        '{id_ny2, id_ay, id_dx, 1'b0},
        '{id_nz2, id_az, id_dy, 1'b0}
    };

endpackage
